//--- design/pu_pkg.sv
// Bases are byte addresses and the bus carries word addresses; FRAME_BITS must be a power of two
package pu_pkg;

  //////////////////////////////////////////////////////////////////////
  // Peripheral bus
  //////////////////////////////////////////////////////////////////////

  localparam int PER_AW = 14;                 // Word address width

  typedef logic [PER_AW-1:0] per_addr_t;      // Word address
  typedef logic [15:0]       per_data_t;      // Bus and DAC data word

  // One request per cycle, no back-pressure
  typedef struct packed {
    per_addr_t  addr;                         // Word address
    per_data_t  din;                          // Write data
    logic [1:0] we;                           // Byte write strobes
    logic       en;                           // Access enable
  } per_req_t;                                // 33 bits

  //////////////////////////////////////////////////////////////////////
  // DAC channel
  //////////////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    DAC_IDLE  = 2'd0,                         // sync_n high, sclk parked high
    DAC_SHIFT = 2'd1,                         // Frame bits on din
    DAC_END   = 2'd2                          // Closing half period
  } dac_state_t;

  localparam int FRAME_BITS   = 16;           // Bits per SPI frame
  localparam int SCLK_DIV_DEF = 1;            // Half period is SCLK_DIV+1 cycles

  //////////////////////////////////////////////////////////////////////
  // Address map
  //////////////////////////////////////////////////////////////////////

  // IN, OUT and DIR at byte offsets 0, 2 and 4
  localparam logic [15:0] GPIO_BASE = 16'h0020;

  // DATA and STATUS at byte offsets 0 and 2 of each channel
  localparam logic [15:0] DAC_X_BASE_DEF = 16'h0190;
  localparam logic [15:0] DAC_Y_BASE_DEF = 16'h0194;

endpackage

//--- design/dac_ctrl_fsm.sv
// Start must only arrive while idle; frame end relies on the timer's last_bit dropping on time
`timescale 1ns/1ns

module dac_ctrl_fsm import pu_pkg::*; (
  input  logic mclk,            // Main clock
  input  logic arst_n,          // Async reset, active low
  input  logic start,           // Frame request, one cycle
  input  logic fall_tick,       // sclk falls at this edge
  input  logic last_bit,        // Final bit period in progress
  output logic busy,            // Frame in flight
  output logic sync_n,          // Frame sync, active low
  output logic run,             // Timer enable
  output logic load             // Shifter load pulse
);

  //////////////////////////////////////////////////////////////////////
  // State register
  //////////////////////////////////////////////////////////////////////

  dac_state_t state;
  dac_state_t state_nxt;

  always_ff @(posedge mclk or negedge arst_n) begin
    if (!arst_n) begin
      state <= DAC_IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Next state
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_nxt = state;
    case (state)
      DAC_IDLE: begin
        if (start) state_nxt = DAC_SHIFT;                 // Frame word loaded here
      end
      DAC_SHIFT: begin
        if (fall_tick && last_bit) state_nxt = DAC_END;   // 16th falling edge
      end
      DAC_END: begin
        // last_bit drops on the tick that closes the half period
        if (!last_bit) state_nxt = DAC_IDLE;
      end
      default: begin
        state_nxt = DAC_IDLE;                             // Unused encoding
      end
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Outputs
  //////////////////////////////////////////////////////////////////////

  assign busy   = (state != DAC_IDLE);
  assign sync_n = ~busy;                                  // Low for the whole frame
  assign run    = busy;                                   // sclk runs through END
  assign load   = (state == DAC_IDLE) & start;            // Same cycle as start

  // The channel must hold off requests until the frame is done
  a_no_start_busy: assert property (@(posedge mclk) disable iff (!arst_n)
    start |-> !busy)
    else $error("DAC start raised while a frame is in flight");

endmodule

//--- design/dac_sclk_timer.sv
// sclk idles high; the fall count wraps after FRAME_BITS edges, so FRAME_BITS is a power of two
`timescale 1ns/1ns

module dac_sclk_timer import pu_pkg::*; #(
  parameter int SCLK_DIV = SCLK_DIV_DEF           // Half period minus one
) (
  input  logic mclk,            // Main clock
  input  logic arst_n,          // Async reset, active low
  input  logic run,             // Frame active
  output logic sclk,            // SPI clock
  output logic fall_tick,       // sclk falls at this edge
  output logic rise_tick,       // sclk rises at this edge
  output logic last_bit         // Final bit period in progress
);

  localparam int HW = (SCLK_DIV > 0) ? $clog2(SCLK_DIV + 1) : 1;
  localparam int BW = $clog2(FRAME_BITS);
  localparam logic [HW-1:0] HALF_LOAD = HW'(SCLK_DIV);

  logic [HW-1:0] half_cnt;      // Cycles left in half period
  logic [BW-1:0] fall_cnt;      // Falling edges so far
  logic          tick;          // Toggle at this edge

  assign tick      = run & (half_cnt == '0);
  assign fall_tick = tick & sclk;
  assign rise_tick = tick & ~sclk;

  always_ff @(posedge mclk or negedge arst_n) begin
    if (!arst_n) begin
      half_cnt <= HALF_LOAD;
      sclk     <= 1'b1;
      fall_cnt <= '0;
    end else if (!run) begin
      half_cnt <= HALF_LOAD;                      // Parked between frames
      sclk     <= 1'b1;
      fall_cnt <= '0;
    end else if (tick) begin
      half_cnt <= HALF_LOAD;
      sclk     <= ~sclk;
      if (sclk) fall_cnt <= fall_cnt + 1'b1;      // Wraps on the last edge
    end else begin
      half_cnt <= half_cnt - 1'b1;
    end
  end

  // High from the 15th fall until the tick that ends the closing low phase
  assign last_bit = (fall_cnt == BW'(FRAME_BITS - 1))
                  | ((fall_cnt == '0) & ~sclk & ~tick);

endmodule

//--- design/dac_shifter.sv
// Frame goes out MSB first; din returns low once all bits have been shifted out
`timescale 1ns/1ns

module dac_shifter import pu_pkg::*; (
  input  logic      mclk,       // Main clock
  input  logic      arst_n,     // Async reset, active low
  input  logic      load,       // Capture new frame
  input  per_data_t frame,      // Frame word
  input  logic      rise_tick,  // sclk rises at this edge
  output logic      din         // SPI serial data
);

  localparam int DW = $bits(per_data_t);

  //////////////////////////////////////////////////////////////////////
  // Shift register
  //////////////////////////////////////////////////////////////////////

  per_data_t shift_q;           // Bits still to send

  always_ff @(posedge mclk or negedge arst_n) begin
    if (!arst_n) begin
      shift_q <= '0;                              // din low after reset
    end else if (load) begin
      shift_q <= frame;                           // MSB on din right away
    end else if (rise_tick) begin
      // Next bit after each rising edge, stable at the falling one
      shift_q <= {shift_q[DW-2:0], 1'b0};
    end
  end

  assign din = shift_q[DW-1];

endmodule

//--- design/dac_channel.sv
// DATA takes the full word on any strobe; a DATA write during a frame is dropped without notice
`timescale 1ns/1ns

module dac_channel import pu_pkg::*; #(
  parameter logic [15:0] BASE_ADDR = DAC_X_BASE_DEF,   // Byte address of DATA
  parameter int          SCLK_DIV  = SCLK_DIV_DEF      // sclk half period minus one
) (
  input  logic      mclk,       // Main clock
  input  logic      arst_n,     // Async reset, active low
  input  per_req_t  per_req,    // Peripheral bus request
  output per_data_t rd_data,    // Read data, zero when not addressed
  output logic      din,        // SPI serial data
  output logic      sclk,       // SPI clock
  output logic      sync_n      // Frame sync, active low
);

  //////////////////////////////////////////////////////////////////////
  // Register decode
  //////////////////////////////////////////////////////////////////////

  localparam per_addr_t DATA_ADDR = BASE_ADDR[PER_AW:1];        // Byte to word
  localparam per_addr_t STAT_ADDR = per_addr_t'(DATA_ADDR + 1);

  logic      wr_req;            // Write cycle
  logic      rd_req;           // Read cycle
  logic      hit_data;
  logic      hit_stat;
  logic      accept;            // DATA write taken
  logic      start;             // Registered start pulse
  logic      busy;
  logic      run;
  logic      load;
  logic      fall_tick;
  logic      rise_tick;
  logic      last_bit;
  per_data_t data_q;            // Last accepted word

  assign wr_req   = per_req.en & (|per_req.we);
  assign rd_req   = per_req.en & (per_req.we == 2'b00);
  assign hit_data = (per_req.addr == DATA_ADDR);
  assign hit_stat = (per_req.addr == STAT_ADDR);

  // Pending start counts as busy so a second write cannot slip in
  assign accept = wr_req & hit_data & ~busy & ~start;

  always_ff @(posedge mclk or negedge arst_n) begin
    if (!arst_n) begin
      data_q <= '0;
      start  <= 1'b0;
    end else begin
      if (accept) data_q <= per_req.din;
      start <= accept;                            // Frame begins one edge later
    end
  end

  // STATUS is read-only
  always_comb begin
    rd_data = '0;
    if (rd_req && hit_data) rd_data = data_q;
    if (rd_req && hit_stat) rd_data = {15'h0000, busy};
  end

  //////////////////////////////////////////////////////////////////////
  // Frame engine
  //////////////////////////////////////////////////////////////////////

  dac_ctrl_fsm u_fsm (
    .mclk     (mclk),
    .arst_n   (arst_n),
    .start    (start),
    .fall_tick(fall_tick),
    .last_bit (last_bit),
    .busy     (busy),
    .sync_n   (sync_n),
    .run      (run),
    .load     (load)
  );

  dac_sclk_timer #(
    .SCLK_DIV(SCLK_DIV)
  ) u_timer (
    .mclk     (mclk),
    .arst_n   (arst_n),
    .run      (run),
    .sclk     (sclk),
    .fall_tick(fall_tick),
    .rise_tick(rise_tick),
    .last_bit (last_bit)
  );

  dac_shifter u_shift (
    .mclk     (mclk),
    .arst_n   (arst_n),
    .load     (load),
    .frame    (data_q),             // Already updated by the accepting edge
    .rise_tick(rise_tick),
    .din      (din)
  );

endmodule

//--- design/per_gpio.sv
// Only the low byte lane is written; IN is read-only and lags the switches by up to 3 cycles
`timescale 1ns/1ns

module per_gpio import pu_pkg::*; (
  input  logic      mclk,       // Main clock
  input  logic      arst_n,     // Async reset, active low
  input  per_req_t  per_req,    // Peripheral bus request
  input  logic [3:0] switch,    // Raw switch levels
  output per_data_t rd_data,    // Read data, zero when not addressed
  output logic [1:0] led        // LED drive
);

  //////////////////////////////////////////////////////////////////////
  // Register decode
  //////////////////////////////////////////////////////////////////////

  localparam per_addr_t IN_ADDR  = GPIO_BASE[PER_AW:1];   // Byte to word
  localparam per_addr_t OUT_ADDR = per_addr_t'(IN_ADDR + 1);
  localparam per_addr_t DIR_ADDR = per_addr_t'(IN_ADDR + 2);

  logic       wr_lo;            // Low byte write
  logic       rd_req;           // Read cycle
  logic       hit_in;
  logic       hit_out;
  logic       hit_dir;
  logic [3:0] sw_meta;          // First sync stage
  logic [3:0] sw_sync;          // Second sync stage
  logic [7:0] out_q;            // OUT register
  logic [7:0] dir_q;            // DIR register

  assign wr_lo   = per_req.en & per_req.we[0];
  assign rd_req  = per_req.en & (per_req.we == 2'b00);
  assign hit_in  = (per_req.addr == IN_ADDR);
  assign hit_out = (per_req.addr == OUT_ADDR);
  assign hit_dir = (per_req.addr == DIR_ADDR);

  //////////////////////////////////////////////////////////////////////
  // Switch synchronizer and output registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge mclk or negedge arst_n) begin
    if (!arst_n) begin
      sw_meta <= '0;
      sw_sync <= '0;
    end else begin
      sw_meta <= switch;        // May go metastable
      sw_sync <= sw_meta;       // Settled copy
    end
  end

  always_ff @(posedge mclk or negedge arst_n) begin
    if (!arst_n) begin
      out_q <= '0;
      dir_q <= '0;
    end else begin
      if (wr_lo && hit_out) out_q <= per_req.din[7:0];
      if (wr_lo && hit_dir) dir_q <= per_req.din[7:0];
    end
  end

  // Combinational read, OR-ed at the top
  always_comb begin
    rd_data = '0;
    if (rd_req) begin
      if (hit_in)  rd_data = {12'h000, sw_sync};
      if (hit_out) rd_data = {8'h00, out_q};
      if (hit_dir) rd_data = {8'h00, dir_q};
    end
  end

  // Pin driven only where its direction bit is set
  assign led = out_q[1:0] & dir_q[1:0];

  // Idle bus must leave the shared OR clean
  a_idle_quiet: assert property (@(posedge mclk) disable iff (!arst_n)
    !per_req.en |-> (rd_data == '0))
    else $error("GPIO read data not zero on idle bus");

endmodule

//--- design/per_subsys.sv
// Bus comes straight from the ports; DAC bases must not overlap each other or the GPIO range
`timescale 1ns/1ns

module per_subsys import pu_pkg::*; #(
  parameter logic [15:0] DAC_X_BASE = DAC_X_BASE_DEF,  // Byte base of DAC X
  parameter logic [15:0] DAC_Y_BASE = DAC_Y_BASE_DEF,  // Byte base of DAC Y
  parameter int          SCLK_DIV   = SCLK_DIV_DEF     // Shared sclk divider
) (
  input  logic       mclk,      // Main clock
  input  logic       arst_n,    // Async reset, active low
  input  per_req_t   per_req,   // Peripheral bus request
  input  logic [3:0] switch,    // Switch inputs
  output per_data_t  per_dout,  // Combined read data
  output logic [1:0] led,       // LEDs
  output logic       din_x,     // DAC X serial data
  output logic       sclk_x,    // DAC X serial clock
  output logic       sync_n_x,  // DAC X frame sync
  output logic       din_y,     // DAC Y serial data
  output logic       sclk_y,    // DAC Y serial clock
  output logic       sync_n_y   // DAC Y frame sync
);

  per_data_t rd_gpio;
  per_data_t rd_dac_x;
  per_data_t rd_dac_y;

  //////////////////////////////////////////////////////////////////////
  // Peripherals
  //////////////////////////////////////////////////////////////////////

  per_gpio u_gpio (
    .mclk   (mclk),
    .arst_n (arst_n),
    .per_req(per_req),
    .switch (switch),
    .rd_data(rd_gpio),
    .led    (led)
  );

  dac_channel #(
    .BASE_ADDR(DAC_X_BASE),
    .SCLK_DIV (SCLK_DIV)
  ) u_dac_x (
    .mclk   (mclk),
    .arst_n (arst_n),
    .per_req(per_req),
    .rd_data(rd_dac_x),
    .din    (din_x),
    .sclk   (sclk_x),
    .sync_n (sync_n_x)
  );

  dac_channel #(
    .BASE_ADDR(DAC_Y_BASE),
    .SCLK_DIV (SCLK_DIV)
  ) u_dac_y (
    .mclk   (mclk),
    .arst_n (arst_n),
    .per_req(per_req),
    .rd_data(rd_dac_y),
    .din    (din_y),
    .sclk   (sclk_y),
    .sync_n (sync_n_y)
  );

  // Each block zeroes its output unless addressed
  assign per_dout = rd_gpio | rd_dac_x | rd_dac_y;

  // Address decoders must never answer the same read
  a_single_driver: assert property (@(posedge mclk) disable iff (!arst_n)
    $onehot0({|rd_gpio, |rd_dac_x, |rd_dac_y}))
    else $error("More than one peripheral drives read data");

endmodule

//--- bench/tb_model.svh
// Reference rules only; needs pu_pkg imported by the including module, frames assumed MSB first
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// IN shows the synchronized switches in the low nibble, upper bits zero
function automatic per_data_t ref_gpio_in(input logic [3:0] sw);
  return {12'h000, sw};
endfunction

// Pin lit only where OUT and DIR agree
function automatic logic [1:0] ref_led(input logic [7:0] out_v, input logic [7:0] dir_v);
  return out_v[1:0] & dir_v[1:0];
endfunction

// Bits in the order they cross the falling edges with the first one on top
function automatic per_data_t ref_frame(input per_data_t word);
  per_data_t seq;
  seq = '0;
  for (int i = 0; i < FRAME_BITS; i++) begin
    seq = {seq[14:0], word[FRAME_BITS-1-i]};    // MSB goes out first
  end
  return seq;
endfunction

// Galois LFSR, x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
  if (s[0]) begin
    return (s >> 1) ^ 32'h80200003;
  end else begin
    return s >> 1;
  end
endfunction

`endif

//--- bench/tb_per_subsys.sv
// Default parameters only; each bus task returns 1 ns after a rising edge with the bus idle
`timescale 1ns/1ns

module tb_per_subsys import pu_pkg::*; ();

  `include "tb_model.svh"

  localparam int          POLL_LIMIT = 400;            // Polls or cycles per wait
  localparam logic [15:0] IN_A  = GPIO_BASE;
  localparam logic [15:0] OUT_A = GPIO_BASE + 16'd2;
  localparam logic [15:0] DIR_A = GPIO_BASE + 16'd4;
  localparam logic [15:0] DAC_X = DAC_X_BASE_DEF;       // DATA, STATUS at +2
  localparam logic [15:0] DAC_Y = DAC_Y_BASE_DEF;

  typedef struct packed {
    logic [4:0] bits;                                  // Falling edges seen
    per_data_t  data;                                  // Captured din with the first bit on top
  } frame_t;

  logic        mclk = 1'b0;
  logic        arst_n;
  per_req_t    per_req;
  logic [3:0]  switch;
  per_data_t   per_dout;
  logic [1:0]  led;
  logic        din_x;                                  // DAC X pins
  logic        sclk_x;
  logic        sync_n_x;
  logic        din_y;                                  // DAC Y pins
  logic        sclk_y;
  logic        sync_n_y;
  int          checks = 0;
  int          errors = 0;
  logic        timed_out = 1'b0;                       // Any wait gave up
  logic [31:0] lfsr = 32'h3ad10db2;
  per_data_t   exp_x[$];                               // Words owed as frames
  per_data_t   exp_y[$];
  frame_t      frm_x[$];                               // Finished frames
  frame_t      frm_y[$];
  frame_t      cap_x = '0;
  frame_t      cap_y = '0;
  frame_t      got_x;
  frame_t      got_y;
  logic        sclk_q_x = 1'b1;
  logic        sclk_q_y = 1'b1;
  logic        sync_q_x = 1'b1;
  logic        sync_q_y = 1'b1;

  per_subsys u_per_subsys (.*);

  always #2 mclk = ~mclk;                              // 4 ns period

  //////////////////////////////////////////////////////////////////////
  // Checks and bus tasks
  //////////////////////////////////////////////////////////////////////

  function automatic logic [15:0] rand_bits(input int n);
    logic [15:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[14:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);                          // One step per bit
    end
    return v;
  endfunction

  task automatic check_eq(input string name, input logic [15:0] got, input logic [15:0] exp);
    checks++;
    assert (got === exp)
      else begin
        errors++;
        $display("** Error at %0t ns: %s = 0x%04h, expected 0x%04h", $time, name, got, exp);
      end
  endtask

  task automatic check_true(input logic cond, input string what);
    checks++;
    assert (cond)
      else begin
        errors++;
        $display("Failure at %0t ns: %s", $time, what);
      end
  endtask

  task automatic report_timeout(input string what);
    errors++;
    timed_out = 1'b1;                                  // Later waits fall through
    $display("Timeout at %0t ns: %s", $time, what);
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge mclk);
      #1;
    end
  endtask

  task automatic bus_access(input logic [15:0] addr, input logic [1:0] we,
                            input per_data_t wdata, output per_data_t rdata);
    per_req.addr = per_addr_t'(addr >> 1);             // Byte to word
    per_req.din  = wdata;
    per_req.we   = we;
    per_req.en   = 1'b1;
    @(negedge mclk);
    rdata = per_dout;                                  // Settled mid-cycle
    @(posedge mclk);                                   // Write lands here
    #1;
    per_req = '0;
  endtask

  task automatic read_check(input logic [15:0] addr, input per_data_t exp, input string name);
    per_data_t rd;
    bus_access(addr, 2'b00, '0, rd);
    check_eq(name, rd, exp);
  endtask

  task automatic dac_write(input logic [15:0] base, input per_data_t word, input logic taken);
    per_data_t rd_ignored;
    bus_access(base, 2'b11, word, rd_ignored);
    if (taken && base == DAC_X) exp_x.push_back(word);
    if (taken && base == DAC_Y) exp_y.push_back(word);
  endtask

  task automatic wait_busy(input logic [15:0] base, input logic level, input string name);
    per_data_t st;
    int        polls;
    polls = 0;
    bus_access(base + 16'd2, 2'b00, '0, st);
    while (st[0] !== level && !timed_out) begin
      polls++;
      assert (polls < POLL_LIMIT)
        else report_timeout({name, " busy stuck at the wrong level"});
      bus_access(base + 16'd2, 2'b00, '0, st);
    end
  endtask

  task automatic drain();
    int n;
    n = 0;
    while ((exp_x.size() != 0 || exp_y.size() != 0) && !timed_out) begin
      idle(1);
      n++;
      assert (n < POLL_LIMIT) else report_timeout("expected DAC frames never completed");
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // SPI capture and frame compare
  //////////////////////////////////////////////////////////////////////

  always @(negedge mclk) begin                         // sclk fall seen mid-cycle
    if (sclk_q_x && !sclk_x && !sync_n_x) begin
      cap_x.data = {cap_x.data[14:0], din_x};
      cap_x.bits = cap_x.bits + 5'd1;
    end
    if (!sync_q_x && sync_n_x) begin                   // Frame closed
      frm_x.push_back(cap_x);
      cap_x = '0;
    end
    sclk_q_x = sclk_x;
    sync_q_x = sync_n_x;
  end

  always @(negedge mclk) begin
    if (sclk_q_y && !sclk_y && !sync_n_y) begin
      cap_y.data = {cap_y.data[14:0], din_y};
      cap_y.bits = cap_y.bits + 5'd1;
    end
    if (!sync_q_y && sync_n_y) begin
      frm_y.push_back(cap_y);
      cap_y = '0;
    end
    sclk_q_y = sclk_y;
    sync_q_y = sync_n_y;
  end

  always @(posedge mclk) begin
    if (frm_x.size() != 0) begin
      got_x = frm_x.pop_front();
      check_true(exp_x.size() != 0, "DAC X sent a frame that no write started");
      if (exp_x.size() != 0) begin
        check_eq("din_x frame bits", 16'(got_x.bits), 16'(FRAME_BITS));
        check_eq("din_x frame", got_x.data, ref_frame(exp_x.pop_front()));
      end
    end
    if (frm_y.size() != 0) begin
      got_y = frm_y.pop_front();
      check_true(exp_y.size() != 0, "DAC Y sent a frame that no write started");
      if (exp_y.size() != 0) begin
        check_eq("din_y frame bits", 16'(got_y.bits), 16'(FRAME_BITS));
        check_eq("din_y frame", got_y.data, ref_frame(exp_y.pop_front()));
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    per_data_t  wx;
    per_data_t  wy;
    logic [3:0] sw;
    logic [7:0] ov;
    logic [7:0] dv;
    per_req = '0;
    arst_n  = 1'b0;
    sw      = 4'(rand_bits(4));
    switch  = sw;
    repeat (2) @(posedge mclk);
    #1;
    arst_n = 1'b1;

    // Reset state with IN read after the synchronizer fills
    check_eq("led", 16'(led), 16'h0000);
    check_eq("{sclk_x,sync_n_x,sclk_y,sync_n_y}",
             {12'h000, sclk_x, sync_n_x, sclk_y, sync_n_y}, 16'h000f);
    idle(2);
    read_check(IN_A, ref_gpio_in(sw), "IN");
    read_check(OUT_A, 16'h0000, "OUT");
    read_check(DIR_A, 16'h0000, "DIR");
    read_check(DAC_X, 16'h0000, "DAC X DATA");
    read_check(DAC_X + 16'd2, 16'h0000, "DAC X STATUS");
    read_check(DAC_Y, 16'h0000, "DAC Y DATA");
    read_check(DAC_Y + 16'd2, 16'h0000, "DAC Y STATUS");

    repeat (8) begin                                   // Switches through IN
      sw     = 4'(rand_bits(4));
      switch = sw;
      idle(2);                                         // Read in the third cycle
      read_check(IN_A, ref_gpio_in(sw), "IN");
    end

    repeat (8) begin                                   // OUT, DIR and led
      ov = 8'(rand_bits(8));
      dv = 8'(rand_bits(8));
      wx = rand_bits(16);
      bus_access(OUT_A, 2'b11, {wx[15:8], ov}, wy);    // Upper lane must not stick
      bus_access(DIR_A, 2'b01, {wx[7:0], dv}, wy);
      read_check(OUT_A, {8'h00, ov}, "OUT");
      read_check(DIR_A, {8'h00, dv}, "DIR");
      check_eq("led", 16'(led), 16'(ref_led(ov, dv)));
    end

    wx = rand_bits(16);                                // Single frame on X
    dac_write(DAC_X, wx, 1'b1);
    wait_busy(DAC_X, 1'b1, "DAC X");
    check_eq("sync_n_y", 16'(sync_n_y), 16'h0001);
    wait_busy(DAC_X, 1'b0, "DAC X");
    read_check(DAC_X, wx, "DAC X DATA");
    check_eq("sclk_x", 16'(sclk_x), 16'h0001);
    drain();

    for (int i = 0; i < 6; i++) begin                  // Back-to-back frames with some pairs
      wx = rand_bits(16);
      wy = rand_bits(16);
      if (i % 3 != 2) dac_write(DAC_X, wx, 1'b1);
      if (i % 3 != 1) dac_write(DAC_Y, wy, 1'b1);
      idle(1);                                         // Let busy rise first
      wait_busy(DAC_X, 1'b0, "DAC X");
      wait_busy(DAC_Y, 1'b0, "DAC Y");
    end
    drain();

    wx = rand_bits(16);                                // Write during a frame
    dac_write(DAC_X, wx, 1'b1);
    wait_busy(DAC_X, 1'b1, "DAC X");
    dac_write(DAC_X, ~wx, 1'b0);                       // Dropped by the channel
    read_check(DAC_X, wx, "DAC X DATA");
    wait_busy(DAC_X, 1'b0, "DAC X");
    read_check(DAC_X, wx, "DAC X DATA");
    drain();
    idle(4);
    read_check(DAC_X + 16'd2, 16'h0000, "DAC X STATUS");   // No second frame queued

    $display("Checks: %0d  Errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- tb.f
+incdir+bench
design/pu_pkg.sv
design/dac_ctrl_fsm.sv
design/dac_sclk_timer.sv
design/dac_shifter.sv
design/dac_channel.sv
design/per_gpio.sv
design/per_subsys.sv
bench/tb_per_subsys.sv

//--- Makefile
TOP := tb_per_subsys

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f tb.f --top-module per_subsys
	verilator --lint-only --timing -f tb.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f tb.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	! grep -q "RESULT: FAIL" sim.log
	grep -q "RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
